// ==== source/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    // Byte lanes per word, one bank each
    localparam int NUM_LANES = 4;

    // Load and store word
    typedef logic [31:0] data_t;

    // One stored byte
    typedef logic [7:0] byte_t;

    // One bit per lane or bank
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Byte offset inside a row, low two address bits
    typedef logic [1:0] lane_off_t;

    ////////////////////
    // Access size
    ////////////////////

    // Code is byte count minus one
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE  = 2'd0;
    localparam mem_size_t SIZE_HALF  = 2'd1;
    localparam mem_size_t SIZE_THREE = 2'd2;
    localparam mem_size_t SIZE_WORD  = 2'd3;

    // Load context carried from the read strobe to the formatter
    typedef struct packed {
        mem_size_t size;
        logic      sign;
        lane_off_t offset;
    } load_info_t;

endpackage

`default_nettype wire

// ==== source/lane_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_ctrl #(
    parameter int ADDR_W = 10
) (
    input  logic                 we,
    input  logic                 re,
    input  logic [ADDR_W-1:0]    addr,
    input  dmem_pkg::mem_size_t  size,
    input  logic                 sign,
    input  dmem_pkg::data_t      wdata,
    output dmem_pkg::lane_mask_t bank_en,
    output dmem_pkg::lane_mask_t bank_we,
    output logic [ADDR_W-3:0]    bank_row [dmem_pkg::NUM_LANES],
    output dmem_pkg::byte_t      bank_wbyte [dmem_pkg::NUM_LANES],
    output dmem_pkg::load_info_t load_info
);
    import dmem_pkg::*;

    // Row index width inside one bank
    localparam int ROW_W = ADDR_W - 2;

    lane_off_t        offset;
    logic [ROW_W-1:0] base_row;
    logic [ROW_W-1:0] next_row;
    lane_mask_t       lane_mask;
    lane_mask_t       touched;

    ////////////////////
    // Address split
    ////////////////////

    // Low bits pick the first bank, the rest pick the row
    assign offset   = addr[1:0];
    assign base_row = addr[ADDR_W-1:2];

    // Wraps to row zero past the top of memory
    assign next_row = base_row + ROW_W'(1);

    // Lanes covered by the size, counted from lane 0
    always_comb begin
        case (size)
            SIZE_BYTE:  lane_mask = 4'b0001;
            SIZE_HALF:  lane_mask = 4'b0011;
            SIZE_THREE: lane_mask = 4'b0111;
            default:    lane_mask = 4'b1111;
        endcase
    end

    ////////////////////
    // Bank mapping
    ////////////////////

    // Bank b serves lane (b - offset) mod 4
    always_comb begin : bank_map
        lane_off_t lane;
        for (int b = 0; b < NUM_LANES; b++) begin
            lane = lane_off_t'(b) - offset;
            touched[b] = lane_mask[lane];
            // Store byte rotated onto its bank
            bank_wbyte[b] = wdata[8*lane +: 8];
            // Banks below the offset hold the spill into the next row
            if (lane_off_t'(b) < offset) begin
                bank_row[b] = next_row;
            end else begin
                bank_row[b] = base_row;
            end
        end
    end

    // Enable only banks the access touches
    assign bank_en = touched & {NUM_LANES{we | re}};
    assign bank_we = touched & {NUM_LANES{we}};

    // Meaningful only with re high
    assign load_info = '{size: size, sign: sign, offset: offset};

    ////////////////////
    // Checks
    ////////////////////

    // No combined read and write, and a known size on any access
    always_comb begin : strobe_checks
        assert final (!(we && re))
            else $error("lane_ctrl: we and re high in the same cycle");
        assert final (!((we || re) && $isunknown(size)))
            else $error("lane_ctrl: size unknown during an access");
    end

endmodule

`default_nettype wire

// ==== source/byte_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_bank #(
    parameter int ROW_W = 8
) (
    input  logic                clk,
    input  logic                en,
    input  logic                wr,
    input  logic [ROW_W-1:0]    row,
    input  dmem_pkg::byte_t     wbyte,
    output dmem_pkg::byte_t     rbyte
);
    import dmem_pkg::*;

    // Rows in this bank
    localparam int DEPTH = 2 ** ROW_W;

    ////////////////////
    // Storage
    ////////////////////

    // Single port, one byte per row
    byte_t mem [DEPTH];

    // Write at the edge, else registered read
    // Unselected cycles leave rbyte as it was
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr) begin
                mem[row] <= wbyte;
            end else begin
                rbyte <= mem[row];
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Row from lane control must be clean whenever the bank is selected
    row_known_a : assert property (
        @(posedge clk) en |-> !$isunknown(row)
    ) else $error("byte_bank: row unknown while enabled");

endmodule

`default_nettype wire

// ==== source/load_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 re,
    input  dmem_pkg::load_info_t load_info,
    input  dmem_pkg::byte_t      bank_rbyte [dmem_pkg::NUM_LANES],
    output dmem_pkg::data_t      rdata,
    output logic                 rvalid
);
    import dmem_pkg::*;

    logic       rd_pend;
    load_info_t info_q;
    byte_t      ordered [NUM_LANES];
    byte_t      fill;
    data_t      formatted;

    ////////////////////
    // Request stage
    ////////////////////

    // Lines up with the bank read register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            info_q  <= '0;
        end else begin
            rd_pend <= re;
            // Kept until the next load
            if (re) begin
                info_q <= load_info;
            end
        end
    end

    ////////////////////
    // Byte order
    ////////////////////

    // Lane i came from bank (offset + i) mod 4
    always_comb begin : reorder
        lane_off_t bank;
        for (int i = 0; i < NUM_LANES; i++) begin
            bank = lane_off_t'(i) + info_q.offset;
            ordered[i] = bank_rbyte[bank];
        end
    end

    // Sign taken from the top loaded byte; full word never extends
    assign fill = (info_q.sign && (info_q.size != SIZE_WORD)) ?
                  {8{ordered[info_q.size][7]}} : '0;

    // Keep lanes up to size, fill the rest
    always_comb begin : size_mask
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i <= int'(info_q.size)) begin
                formatted[8*i +: 8] = ordered[i];
            end else begin
                formatted[8*i +: 8] = fill;
            end
        end
    end

    ////////////////////
    // Output stage
    ////////////////////

    // rdata holds between loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            rvalid <= rd_pend;
            if (rd_pend) begin
                rdata <= formatted;
            end
        end
    end

    // Valid only ever follows a read strobe by two edges
    no_stray_valid_a : assert property (
        @(posedge clk) disable iff (!rst_n) !re |-> ##2 !rvalid
    ) else $error("load_extend: rvalid without a read two cycles earlier");

endmodule

`default_nettype wire

// ==== source/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int ADDR_W = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  logic                re,
    input  logic [ADDR_W-1:0]   addr,
    input  dmem_pkg::mem_size_t size,
    input  logic                sign,
    input  dmem_pkg::data_t     wdata,
    output dmem_pkg::data_t     rdata,
    output logic                rvalid
);
    import dmem_pkg::*;

    // Row index width inside one bank
    localparam int ROW_W = ADDR_W - 2;

    ////////////////////
    // Bank wiring
    ////////////////////

    // Per-bank controls from lane control
    lane_mask_t       bank_en;
    lane_mask_t       bank_we;
    logic [ROW_W-1:0] bank_row [NUM_LANES];
    byte_t            bank_wbyte [NUM_LANES];

    // Read bytes, still in bank order
    byte_t            bank_rbyte [NUM_LANES];

    // Load context for the formatter
    load_info_t       load_info;

    // Address and size to bank selects
    lane_ctrl #(
        .ADDR_W     (ADDR_W)
    ) lane_ctrl_u (
        .we         (we),
        .re         (re),
        .addr       (addr),
        .size       (size),
        .sign       (sign),
        .wdata      (wdata),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_row   (bank_row),
        .bank_wbyte (bank_wbyte),
        .load_info  (load_info)
    );

    // One bank per byte lane, interleaved on addr[1:0]
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_bank
        byte_bank #(
            .ROW_W (ROW_W)
        ) bank_u (
            .clk   (clk),
            .en    (bank_en[g]),
            .wr    (bank_we[g]),
            .row   (bank_row[g]),
            .wbyte (bank_wbyte[g]),
            .rbyte (bank_rbyte[g])
        );
    end

    ////////////////////
    // Load path
    ////////////////////

    // Reorder, extend and register
    load_extend load_extend_u (
        .clk        (clk),
        .rst_n      (rst_n),
        .re         (re),
        .load_info  (load_info),
        .bank_rbyte (bank_rbyte),
        .rdata      (rdata),
        .rvalid     (rvalid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem;
    import dmem_pkg::*;

    ////////////////////
    // Run constants
    ////////////////////

    localparam int ADDR_W       = 10;
    localparam int MEM_BYTES    = 2 ** ADDR_W;
    localparam int CLK_HALF     = 20;
    localparam int DRV_DLY      = 2;
    localparam int RST_CYCLES   = 4;
    // One full-word store per row to preload the memory
    localparam int FILL_OPS     = MEM_BYTES / NUM_LANES;
    localparam int DIRECTED_OPS = 160;
    localparam int RANDOM_OPS   = 400;
    // At most two cycles per access with gaps, then doubled for margin
    localparam int MAX_CYCLES   = 2 * (RST_CYCLES + FILL_OPS + 2 * (DIRECTED_OPS + RANDOM_OPS));

    // Byte address
    typedef logic [ADDR_W-1:0] baddr_t;

    logic      clk;
    logic      rst_n;
    logic      we;
    logic      re;
    baddr_t    addr;
    mem_size_t size;
    logic      sign;
    data_t     wdata;
    data_t     rdata;
    logic      rvalid;

    // Reference byte model
    byte_t     ref_mem [MEM_BYTES];
    // Expected word of the load being driven
    data_t     load_exp;
    data_t     exp_q [$];
    logic      re_d1;
    logic      exp_rvalid;
    data_t     exp_rdata;

    int        seed;
    int        cycle_cnt     = 0;
    int        loads_checked = 0;
    int        value_errs    = 0;

    data_mem #(
        .ADDR_W (ADDR_W)
    ) data_mem_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (we),
        .re     (re),
        .addr   (addr),
        .size   (size),
        .sign   (sign),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Preload value, mixes every address bit
    function automatic byte_t fill_byte(input baddr_t a);
        return byte_t'(a * 7) ^ byte_t'(a >> 3) ^ 8'h5A;
    endfunction

    // Lane i lands at addr + i, wrapping at the top
    function automatic void model_store(input baddr_t a, input mem_size_t sz, input data_t d);
        for (int i = 0; i <= int'(sz); i++) begin
            ref_mem[(int'(a) + i) % MEM_BYTES] = d[8*i +: 8];
        end
    endfunction

    // Bytes up to size from memory, the rest zero or copies of the top sign bit
    function automatic data_t expected_load(input baddr_t a, input mem_size_t sz, input logic sg);
        data_t word;
        byte_t top;
        byte_t ext;
        top = ref_mem[(int'(a) + int'(sz)) % MEM_BYTES];
        ext = (sg && (sz != SIZE_WORD) && top[7]) ? 8'hFF : 8'h00;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i <= int'(sz)) begin
                word[8*i +: 8] = ref_mem[(int'(a) + i) % MEM_BYTES];
            end else begin
                word[8*i +: 8] = ext;
            end
        end
        return word;
    endfunction

    // Expected valid and data, two edges behind the read strobe
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_d1      <= 1'b0;
            exp_rvalid <= 1'b0;
            exp_rdata  <= '0;
            exp_q.delete();
        end else begin
            re_d1      <= re;
            exp_rvalid <= re_d1;
            // Oldest load result is due now
            if (re_d1) begin
                exp_rdata <= exp_q.pop_front();
                loads_checked++;
            end
            if (re) begin
                exp_q.push_back(load_exp);
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Outputs clear once reset lifts
    reset_state_a : assert property (
        @(posedge clk) $rose(rst_n) |-> (rvalid === 1'b0 && rdata === '0)
    ) else begin
        value_errs++;
        $display("ERR %0t rvalid/rdata after reset: got %0b/%08h expected 0/00000000",
                 $time, $sampled(rvalid), $sampled(rdata));
    end

    // One pulse per read, none otherwise
    rvalid_a : assert property (
        @(posedge clk) disable iff (!rst_n) rvalid === exp_rvalid
    ) else begin
        value_errs++;
        $display("ERR %0t rvalid: got %0b expected %0b",
                 $time, $sampled(rvalid), $sampled(exp_rvalid));
    end

    // Also covers rdata holding between loads
    rdata_a : assert property (
        @(posedge clk) disable iff (!rst_n) rdata === exp_rdata
    ) else begin
        value_errs++;
        $display("ERR %0t rdata: got %08h expected %08h",
                 $time, $sampled(rdata), $sampled(exp_rdata));
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic report_counts();
        $display("Loads checked %0d, value errors %0d", loads_checked, value_errs);
    endtask

    ////////////////////
    // Bus operations
    ////////////////////

    task automatic store_op(input baddr_t a, input mem_size_t sz, input data_t d);
        we    = 1'b1;
        re    = 1'b0;
        addr  = a;
        size  = sz;
        sign  = 1'b0;
        wdata = d;
        model_store(a, sz, d);
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic load_op(input baddr_t a, input mem_size_t sz, input logic sg);
        we       = 1'b0;
        re       = 1'b1;
        addr     = a;
        size     = sz;
        sign     = sg;
        load_exp = expected_load(a, sz, sg);
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic idle_op(input int n);
        we = 1'b0;
        re = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    ////////////////////
    // Test sequences
    ////////////////////

    task automatic fill_memory();
        data_t w;
        for (int r = 0; r < FILL_OPS; r++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                w[8*i +: 8] = fill_byte(baddr_t'(4 * r + i));
            end
            store_op(baddr_t'(4 * r), SIZE_WORD, w);
        end
    endtask

    task automatic word_round_trip();
        for (int k = 0; k < 8; k++) begin
            store_op(baddr_t'(k * 132), SIZE_WORD, data_t'($random(seed)));
            load_op(baddr_t'(k * 132), SIZE_WORD, 1'b0);
        end
        // Same words again, back to back
        for (int k = 0; k < 8; k++) begin
            load_op(baddr_t'(k * 132), SIZE_WORD, 1'b1);
        end
        store_op(10'h3FC, SIZE_WORD, 32'hDEADBEEF);
        load_op(10'h3FC, SIZE_WORD, 1'b1);
        idle_op(2);
    endtask

    // Upper wdata bytes set so a stray lane write shows up
    task automatic partial_writes();
        baddr_t base;
        for (int k = 0; k < NUM_LANES; k++) begin
            base = baddr_t'(10'h040 + 16 * k);
            store_op(base, SIZE_WORD, 32'h11223344);
            store_op(base + baddr_t'(4), SIZE_WORD, 32'h55667788);
            store_op(base + baddr_t'(k), SIZE_BYTE, 32'hFFFFFFA5);
            load_op(base, SIZE_WORD, 1'b0);
            store_op(base + baddr_t'(k), SIZE_HALF, 32'hFFFFC3B2);
            load_op(base, SIZE_WORD, 1'b0);
            load_op(base + baddr_t'(4), SIZE_WORD, 1'b0);
            store_op(base + baddr_t'(k), SIZE_THREE, 32'hFF0D0E0F);
            load_op(base, SIZE_WORD, 1'b0);
            load_op(base + baddr_t'(4), SIZE_WORD, 1'b0);
        end
    endtask

    task automatic unaligned_wrap();
        baddr_t a;
        // Row crossing at each offset
        for (int off = 1; off < NUM_LANES; off++) begin
            a = baddr_t'(10'h080 + off);
            store_op(a, SIZE_WORD, data_t'($random(seed)));
            load_op(a, SIZE_WORD, 1'b0);
            load_op(a - baddr_t'(off), SIZE_WORD, 1'b0);
            load_op(a - baddr_t'(off) + baddr_t'(4), SIZE_WORD, 1'b0);
            load_op(a, SIZE_HALF, 1'b1);
        end
        // Top byte wraps to address zero
        for (int s = 0; s < NUM_LANES; s++) begin
            store_op(10'h3FF, mem_size_t'(s), data_t'($random(seed)));
            load_op(10'h3FF, SIZE_WORD, 1'b0);
            load_op(10'h000, SIZE_WORD, 1'b0);
            load_op(10'h3FE, mem_size_t'(s), 1'b1);
        end
        store_op(10'h3FD, SIZE_WORD, 32'h89ABCDEF);
        load_op(10'h3FD, SIZE_THREE, 1'b1);
        load_op(10'h3FC, SIZE_WORD, 1'b0);
        load_op(10'h000, SIZE_WORD, 1'b0);
    endtask

    task automatic extension_loads();
        // Bytes from 0x0C0 up: 01 FF 80 7F 80 7F FF 00
        store_op(10'h0C0, SIZE_WORD, 32'h7F80FF01);
        store_op(10'h0C4, SIZE_WORD, 32'h00FF7F80);
        // Top byte sign bit both set and clear for every size
        for (int s = 0; s < NUM_LANES; s++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int a = 0; a < NUM_LANES; a++) begin
                    load_op(baddr_t'(10'h0C0 + a), mem_size_t'(s), sg[0]);
                end
            end
        end
    endtask

    task automatic valid_timing();
        // Lone read between gaps
        load_op(10'h010, SIZE_WORD, 1'b0);
        idle_op(3);
        // Burst of reads
        for (int k = 0; k < 8; k++) begin
            load_op(baddr_t'(10'h011 + 3 * k), mem_size_t'(k), k[0]);
        end
        idle_op(1);
        // Reads and stores interleaved
        load_op(10'h020, SIZE_WORD, 1'b0);
        store_op(10'h020, SIZE_HALF, 32'h0000ABCD);
        load_op(10'h020, SIZE_WORD, 1'b0);
        store_op(10'h021, SIZE_BYTE, 32'h00000099);
        idle_op(2);
        load_op(10'h020, SIZE_WORD, 1'b1);
        idle_op(4);
    endtask

    task automatic random_mix();
        int        r;
        baddr_t    a;
        mem_size_t sz;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r  = $random(seed);
            a  = baddr_t'($random(seed));
            sz = mem_size_t'(r[3:2]);
            if (r[0]) begin
                store_op(a, sz, data_t'($random(seed)));
            end else begin
                load_op(a, sz, r[1]);
            end
            // Occasional gap
            if (r[6:4] == 3'd0) begin
                idle_op(1);
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed     = 47736;
        rst_n    = 1'b0;
        we       = 1'b0;
        re       = 1'b0;
        addr     = '0;
        size     = SIZE_BYTE;
        sign     = 1'b0;
        wdata    = '0;
        load_exp = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        fill_memory();
        word_round_trip();
        partial_writes();
        unaligned_wrap();
        extension_loads();
        valid_timing();
        random_mix();
        idle_op(4);

        report_counts();
        if (value_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/dmem_pkg.sv
source/lane_ctrl.sv
source/byte_bank.sv
source/load_extend.sv
source/data_mem.sv
sim/tb_data_mem.sv
